//--- compile.f
src/cache_pkg.sv
src/cache_array_if.sv
src/line_store.sv
src/tag_store.sv
src/way_select.sv
src/cache_control.sv
src/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

//--- run_sim.sh
#!/bin/bash
# build and run the cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module cache_tb -o cache_sim

sim_out=$(./obj_dir/cache_sim)
echo "$sim_out"

if echo "$sim_out" | grep -q "Done: no errors"; then
    exit 0
else
    exit 1
fi

//--- src/cache_array_if.sv
`default_nettype none

interface cache_array_if #(
    parameter int index_w = cache_pkg::index_w_default
) ();

    localparam int num_sets = 2 ** index_w;

    // data line write, one strobe per way
    logic [cache_pkg::num_ways-1:0] data_we;

    // line fill from memory, full mask
    // cpu write data under byte enable otherwise
    logic fill;

    // tag write, also marks the line valid
    logic [cache_pkg::num_ways-1:0] tag_we;

    // dirty bit update and its new value
    logic [cache_pkg::num_ways-1:0] dirty_we;
    logic dirty_val;

    // replacement update, one strobe per set
    logic [num_sets-1:0] repl_we;

    // hit way, or victim way on a miss
    logic way;
    logic hit;

    // controller drives every write control
    modport ctrl (
        output data_we, fill, tag_we, dirty_we, dirty_val, repl_we,
        input  way, hit
    );

    // line and tag arrays
    modport store (
        input data_we, fill, tag_we, dirty_we, dirty_val, way
    );

    // compare and replacement logic
    modport sel (
        input  repl_we,
        output way, hit
    );

endinterface

`default_nettype wire

//--- src/cache_control.sv
`default_nettype none

module cache_control #(
    parameter  int index_w = cache_pkg::index_w_default,
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          mem_read,
    input  wire                          mem_write,
    input  wire  [tag_w-1:0]             mem_tag,
    input  wire  [index_w-1:0]           mem_set,
    input  wire  [tag_w-1:0]             victim_tag,
    input  wire                          victim_dirty,
    input  wire  [cache_pkg::line_w-1:0] victim_line,
    input  wire                          pmem_resp,
    output logic                         mem_resp,
    output logic [cache_pkg::addr_w-1:0] pmem_address,
    output logic                         pmem_read,
    output logic                         pmem_write,
    output logic [cache_pkg::line_w-1:0] pmem_wdata,
    cache_array_if.ctrl                  arr
);

    // state encoding
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_cache_rw = 2'd1;
    localparam logic [1:0] st_pmem_r   = 2'd2;
    localparam logic [1:0] st_pmem_w   = 2'd3;

    logic [1:0] state_q;
    logic [1:0] state_d;

    cache_pkg::cache_addr_u line_addr;
    logic [tag_w-1:0]       line_tag;

    // ******************************
    // FSM
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (mem_read || mem_write) begin
                    state_d = st_cache_rw;
                end
            end
            // hit answers, miss goes to memory
            // dirty victim is written back first
            st_cache_rw: begin
                if (arr.hit) begin
                    state_d = st_idle;
                end else if (victim_dirty) begin
                    state_d = st_pmem_w;
                end else begin
                    state_d = st_pmem_r;
                end
            end
            // back to cache_rw, which then hits
            st_pmem_r: begin
                if (pmem_resp) begin
                    state_d = st_cache_rw;
                end
            end
            st_pmem_w: begin
                if (pmem_resp) begin
                    state_d = st_pmem_r;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // ******************************
    // array controls and handshakes
    // ******************************

    always_comb begin
        arr.data_we   = '0;
        arr.fill      = 1'b0;
        arr.tag_we    = '0;
        arr.dirty_we  = '0;
        arr.dirty_val = 1'b0;
        arr.repl_we   = '0;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        case (state_q)
            st_cache_rw: begin
                if (arr.hit) begin
                    // one-cycle response pulse, touch replacement
                    mem_resp              = 1'b1;
                    arr.repl_we[mem_set]  = 1'b1;
                    // write hit merges cpu bytes, line turns dirty
                    if (mem_write) begin
                        arr.data_we[arr.way]  = 1'b1;
                        arr.dirty_we[arr.way] = 1'b1;
                        arr.dirty_val         = 1'b1;
                    end
                end
            end
            st_pmem_r: begin
                pmem_read = 1'b1;
                // fill lands in the victim way, clean and valid
                if (pmem_resp) begin
                    arr.fill              = 1'b1;
                    arr.data_we[arr.way]  = 1'b1;
                    arr.tag_we[arr.way]   = 1'b1;
                    arr.dirty_we[arr.way] = 1'b1;
                end
            end
            st_pmem_w: begin
                pmem_write = 1'b1;
                // writeback done, line now matches memory
                if (pmem_resp) begin
                    arr.dirty_we[arr.way] = 1'b1;
                end
            end
            default: begin
            end
        endcase
    end

    // victim address during writeback, request address otherwise
    assign line_tag = (state_q == st_pmem_w) ? victim_tag : mem_tag;

    // line-aligned, offset field stays zero
    always_comb begin
        line_addr = '0;
        {line_addr.fields.tag, line_addr.fields.set} = {line_tag, mem_set};
    end

    assign pmem_address = line_addr.flat;

    // only sampled by memory while pmem_write is high
    assign pmem_wdata = victim_line;

endmodule

`default_nettype wire

//--- src/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ******************************
    // cache geometry
    // ******************************

    // cpu byte address
    parameter int addr_w = 32;

    // byte offset inside one line
    parameter int offset_w = 5;

    // one enable bit per byte lane
    parameter int mask_w = 2 ** offset_w;

    // full line, 256 bits
    parameter int line_w = 8 * mask_w;

    // two-way set associative
    parameter int num_ways = 2;

    // default set index width, gives 16 sets
    parameter int index_w_default = 4;
    parameter int tag_w_default = addr_w - index_w_default - offset_w;

    // ******************************
    // address views
    // ******************************

    // same word seen flat (ports, memory side) or split into fields
    // tag and set together always span addr_w - offset_w bits,
    // so a narrower or wider index just moves the boundary
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [tag_w_default-1:0]   tag;
            logic [index_w_default-1:0] set;
            logic [offset_w-1:0]        offset;
        } fields;
    } cache_addr_u;

endpackage

`default_nettype wire

//--- src/cache_top.sv
`default_nettype none

module cache_top #(
    parameter  int index_w = cache_pkg::index_w_default,
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w
) (
    input  wire                          clk,
    input  wire                          rst,

    // cpu side
    input  wire  [cache_pkg::addr_w-1:0] mem_address,
    input  wire                          mem_read,
    input  wire                          mem_write,
    input  wire  [cache_pkg::mask_w-1:0] mem_byte_enable,
    input  wire  [cache_pkg::line_w-1:0] mem_wdata,
    output logic [cache_pkg::line_w-1:0] mem_rdata,
    output logic                         mem_resp,

    // memory side
    output logic [cache_pkg::addr_w-1:0] pmem_address,
    output logic                         pmem_read,
    output logic                         pmem_write,
    output logic [cache_pkg::line_w-1:0] pmem_wdata,
    input  wire  [cache_pkg::line_w-1:0] pmem_rdata,
    input  wire                          pmem_resp
);

    localparam int line_num_w = cache_pkg::addr_w - cache_pkg::offset_w;

    cache_pkg::cache_addr_u req_addr;

    logic [line_num_w-1:0]        line_num;
    logic [tag_w-1:0]             mem_tag;
    logic [index_w-1:0]           mem_set;
    logic [tag_w-1:0]             tag0;
    logic [tag_w-1:0]             tag1;
    logic                         valid0;
    logic                         valid1;
    logic [tag_w-1:0]             victim_tag;
    logic                         victim_dirty;
    logic [cache_pkg::line_w-1:0] victim_line;

    // ******************************
    // address decode
    // ******************************

    // offset is dropped, the cpu port moves whole lines
    assign req_addr = mem_address;
    assign line_num = {req_addr.fields.tag, req_addr.fields.set};

    // low bits of the line number index the set
    assign mem_set = line_num[index_w-1:0];
    assign mem_tag = line_num[line_num_w-1 -: tag_w];

    // ******************************
    // instances
    // ******************************

    cache_array_if #(.index_w(index_w)) arr0 ();

    cache_control #(.index_w(index_w)) ctrl0 (
        .clk          (clk),
        .rst          (rst),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .mem_tag      (mem_tag),
        .mem_set      (mem_set),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .victim_line  (victim_line),
        .pmem_resp    (pmem_resp),
        .mem_resp     (mem_resp),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .arr          (arr0.ctrl)
    );

    // selected line doubles as read data
    line_store #(.index_w(index_w)) lines0 (
        .clk             (clk),
        .mem_set         (mem_set),
        .mem_wdata       (mem_wdata),
        .mem_byte_enable (mem_byte_enable),
        .pmem_rdata      (pmem_rdata),
        .arr             (arr0.store),
        .way_line        (mem_rdata),
        .victim_line     (victim_line)
    );

    tag_store #(.index_w(index_w)) tags0 (
        .clk          (clk),
        .rst          (rst),
        .mem_set      (mem_set),
        .mem_tag      (mem_tag),
        .arr          (arr0.store),
        .tag0         (tag0),
        .tag1         (tag1),
        .valid0       (valid0),
        .valid1       (valid1),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    way_select #(.index_w(index_w)) sel0 (
        .clk     (clk),
        .rst     (rst),
        .mem_tag (mem_tag),
        .mem_set (mem_set),
        .tag0    (tag0),
        .tag1    (tag1),
        .valid0  (valid0),
        .valid1  (valid1),
        .arr     (arr0.sel)
    );

endmodule

`default_nettype wire

//--- src/line_store.sv
`default_nettype none

module line_store #(
    parameter int index_w = cache_pkg::index_w_default
) (
    input  wire                          clk,
    input  wire  [index_w-1:0]           mem_set,
    input  wire  [cache_pkg::line_w-1:0] mem_wdata,
    input  wire  [cache_pkg::mask_w-1:0] mem_byte_enable,
    input  wire  [cache_pkg::line_w-1:0] pmem_rdata,
    cache_array_if.store                 arr,
    output logic [cache_pkg::line_w-1:0] way_line,
    output logic [cache_pkg::line_w-1:0] victim_line
);

    localparam int num_sets = 2 ** index_w;

    // line storage, flops in place of sram
    logic [cache_pkg::line_w-1:0] lines [cache_pkg::num_ways][num_sets];

    logic [cache_pkg::line_w-1:0] wr_data;
    logic [cache_pkg::mask_w-1:0] wr_mask;
    logic [cache_pkg::line_w-1:0] sel_line;

    // fill takes the whole line, cpu write only its enabled lanes
    assign wr_data = arr.fill ? pmem_rdata : mem_wdata;
    assign wr_mask = arr.fill ? {cache_pkg::mask_w{1'b1}} : mem_byte_enable;

    // byte-masked write on the strobed way
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            for (int b = 0; b < cache_pkg::mask_w; b++) begin
                if (arr.data_we[w] && wr_mask[b]) begin
                    lines[w][mem_set][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // combinational read of the selected way
    assign sel_line = lines[arr.way][mem_set];

    // hit way on a hit, victim way on a miss
    assign way_line    = sel_line;
    assign victim_line = sel_line;

endmodule

`default_nettype wire

//--- src/tag_store.sv
`default_nettype none

module tag_store #(
    parameter  int index_w = cache_pkg::index_w_default,
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w
) (
    input  wire                clk,
    input  wire                rst,
    input  wire  [index_w-1:0] mem_set,
    input  wire  [tag_w-1:0]   mem_tag,
    cache_array_if.store       arr,
    output logic [tag_w-1:0]   tag0,
    output logic [tag_w-1:0]   tag1,
    output logic               valid0,
    output logic               valid1,
    output logic [tag_w-1:0]   victim_tag,
    output logic               victim_dirty
);

    localparam int num_sets = 2 ** index_w;

    // ******************************
    // storage
    // ******************************

    // tags, meaningful only while valid
    logic [tag_w-1:0] tags [cache_pkg::num_ways][num_sets];

    // valid and dirty, one bit per set per way
    logic [cache_pkg::num_ways-1:0][num_sets-1:0] valid_q;
    logic [cache_pkg::num_ways-1:0][num_sets-1:0] dirty_q;

    // new tag always comes from the request
    always_ff @(posedge clk) begin
        for (int w = 0; w < cache_pkg::num_ways; w++) begin
            if (arr.tag_we[w]) begin
                tags[w][mem_set] <= mem_tag;
            end
        end
    end

    // all lines invalid and clean out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            for (int w = 0; w < cache_pkg::num_ways; w++) begin
                // tag write brings the line in
                if (arr.tag_we[w]) begin
                    valid_q[w][mem_set] <= 1'b1;
                end
                if (arr.dirty_we[w]) begin
                    dirty_q[w][mem_set] <= arr.dirty_val;
                end
            end
        end
    end

    // ******************************
    // read side
    // ******************************

    // both ways of the set go to the comparators
    assign tag0   = tags[0][mem_set];
    assign tag1   = tags[1][mem_set];
    assign valid0 = valid_q[0][mem_set];
    assign valid1 = valid_q[1][mem_set];

    // victim view, invalid lines count as clean
    assign victim_tag   = tags[arr.way][mem_set];
    assign victim_dirty = valid_q[arr.way][mem_set] && dirty_q[arr.way][mem_set];

endmodule

`default_nettype wire

//--- src/way_select.sv
`default_nettype none

module way_select #(
    parameter  int index_w = cache_pkg::index_w_default,
    localparam int tag_w   = cache_pkg::addr_w - index_w - cache_pkg::offset_w
) (
    input wire               clk,
    input wire               rst,
    input wire [tag_w-1:0]   mem_tag,
    input wire [index_w-1:0] mem_set,
    input wire [tag_w-1:0]   tag0,
    input wire [tag_w-1:0]   tag1,
    input wire               valid0,
    input wire               valid1,
    cache_array_if.sel       arr
);

    localparam int num_sets = 2 ** index_w;

    // per-set bit naming the way to evict next
    logic [num_sets-1:0] repl_q;

    logic match0;
    logic match1;

    // ******************************
    // tag compare
    // ******************************

    // a stale tag never matches once valid is low
    assign match0 = valid0 && (tag0 == mem_tag);
    assign match1 = valid1 && (tag1 == mem_tag);

    assign arr.hit = match0 || match1;

    // way 0 wins a double match
    // on a miss the replacement bit picks the victim
    always_comb begin
        if (match0) begin
            arr.way = 1'b0;
        end else if (match1) begin
            arr.way = 1'b1;
        end else begin
            arr.way = repl_q[mem_set];
        end
    end

    // ******************************
    // replacement bits
    // ******************************

    // after a hit the other way becomes next victim
    // strobe only fires for the set being accessed
    always_ff @(posedge clk) begin
        if (rst) begin
            repl_q <= '0;
        end else begin
            for (int s = 0; s < num_sets; s++) begin
                if (arr.repl_we[s]) begin
                    repl_q[s] <= ~arr.way;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
`default_nettype none

module cache_checker (
    input wire         clk,
    input wire         rst,
    input wire [31:0]  mem_address,
    input wire         mem_read,
    input wire         mem_write,
    input wire [31:0]  mem_byte_enable,
    input wire [255:0] mem_wdata,
    input wire [255:0] mem_rdata,
    input wire         mem_resp,
    input wire [31:0]  pmem_address,
    input wire         pmem_read,
    input wire         pmem_write,
    input wire [255:0] pmem_wdata
);

    int errors;
    int resp_count;
    int cyc;
    int start_cyc;

    // ******************************
    // reference model state
    // ******************************

    // cpu view of memory, bytes never written keep the init pattern
    logic [7:0] shadow [logic [31:0]];

    logic        m_valid [2][16];
    logic        m_dirty [2][16];
    logic [22:0] m_tag   [2][16];
    // way to evict next, per set
    logic        m_repl  [16];

    logic        busy;
    logic        prev_rst;
    logic        exp_hit;
    logic        exp_wb;
    logic        seen_rd;
    logic        seen_wr;
    logic        req_way;
    logic [3:0]  req_set;
    logic [22:0] req_tag;
    logic [31:0] victim_addr;

    initial begin
        errors     = 0;
        resp_count = 0;
        cyc        = 0;
        start_cyc  = 0;
        busy       = 1'b0;
        prev_rst   = 1'b1;
    end

    function automatic logic [255:0] shadow_line(input logic [31:0] base);
        logic [255:0] line;
        logic [31:0]  a;
        for (int i = 0; i < 32; i++) begin
            a = base + i;
            line[8*i +: 8] = shadow.exists(a) ? shadow[a] : (a[7:0] ^ 8'h5a);
        end
        return line;
    endfunction

    task automatic value_error(input string msg);
        errors++;
        $display("** Error at time %0t: %s", $time, msg);
    endtask

    task automatic protocol_error(input string msg);
        errors++;
        $display("checker at time %0t: %s", $time, msg);
    endtask

    // ******************************
    // request start, predict outcome
    // ******************************

    task automatic start_request();
        busy      = 1'b1;
        start_cyc = cyc;
        seen_rd   = 1'b0;
        seen_wr   = 1'b0;
        req_set   = mem_address[8:5];
        req_tag   = mem_address[31:9];
        exp_wb    = 1'b0;
        if (m_valid[0][req_set] && m_tag[0][req_set] == req_tag) begin
            exp_hit = 1'b1;
            req_way = 1'b0;
        end else if (m_valid[1][req_set] && m_tag[1][req_set] == req_tag) begin
            exp_hit = 1'b1;
            req_way = 1'b1;
        end else begin
            exp_hit = 1'b0;
            req_way = m_repl[req_set];
            // invalid lines count as clean
            exp_wb  = m_valid[req_way][req_set] && m_dirty[req_way][req_set];
            victim_addr = {m_tag[req_way][req_set], req_set, 5'b0};
        end
    endtask

    // response edge, compare data and advance the model
    task automatic finish_request();
        logic [31:0] base;
        base = {mem_address[31:5], 5'b0};
        if (exp_hit && (cyc - start_cyc) != 1) begin
            value_error($sformatf("hit latency %0d cycles at %h", cyc - start_cyc + 1,
                                  mem_address));
        end
        if (!exp_hit && !seen_rd) begin
            protocol_error($sformatf("miss at %h answered without a line fill", mem_address));
        end
        if (exp_wb && !seen_wr) begin
            protocol_error("dirty victim was never written back");
        end
        if (mem_read && mem_rdata !== shadow_line(base)) begin
            value_error($sformatf("read %h got %h expected %h", mem_address, mem_rdata,
                                  shadow_line(base)));
        end
        if (mem_write) begin
            for (int i = 0; i < 32; i++) begin
                if (mem_byte_enable[i]) begin
                    shadow[base + i] = mem_wdata[8*i +: 8];
                end
            end
        end
        m_valid[req_way][req_set] = 1'b1;
        m_tag[req_way][req_set]   = req_tag;
        if (!exp_hit) begin
            m_dirty[req_way][req_set] = 1'b0;
        end
        if (mem_write) begin
            m_dirty[req_way][req_set] = 1'b1;
        end
        m_repl[req_set] = ~req_way;
        resp_count++;
        busy = 1'b0;
    endtask

    // ******************************
    // per-cycle watch, mid-cycle sampling
    // ******************************

    always @(negedge clk) begin
        if (rst || prev_rst) begin
            if (mem_resp || pmem_read || pmem_write) begin
                value_error("handshake output high during or right after reset");
            end
            for (int s = 0; s < 16; s++) begin
                m_valid[0][s] = 1'b0;
                m_valid[1][s] = 1'b0;
                m_dirty[0][s] = 1'b0;
                m_dirty[1][s] = 1'b0;
                m_repl[s]     = 1'b0;
            end
            busy = 1'b0;
        end else begin
            cyc++;
            if (!busy && (mem_read || mem_write)) begin
                start_request();
            end
            if (busy) begin
                if (pmem_write && !seen_wr) begin
                    seen_wr = 1'b1;
                    if (!exp_wb) begin
                        protocol_error("pmem_write without a dirty victim");
                    end else begin
                        if (pmem_address !== victim_addr) begin
                            value_error($sformatf("writeback address %h expected %h",
                                                  pmem_address, victim_addr));
                        end
                        if (pmem_wdata !== shadow_line(victim_addr)) begin
                            value_error($sformatf("writeback data %h expected %h",
                                                  pmem_wdata, shadow_line(victim_addr)));
                        end
                    end
                end
                if (pmem_read && !seen_rd) begin
                    seen_rd = 1'b1;
                    if (exp_hit) begin
                        protocol_error("pmem_read on an access that should hit");
                    end
                    if (exp_wb && !seen_wr) begin
                        protocol_error("line fill started before the writeback");
                    end
                    if (pmem_address !== {mem_address[31:5], 5'b0}) begin
                        value_error($sformatf("fill address %h expected %h", pmem_address,
                                              {mem_address[31:5], 5'b0}));
                    end
                end
                if (mem_resp) begin
                    finish_request();
                end
            end else if (mem_resp) begin
                protocol_error("mem_resp with no request");
            end
        end
        prev_rst = rst;
    end

endmodule

`default_nettype wire

//--- testbench/cache_stim.txt
# columns: kind (R/W), address, byte enable, fill byte (all hex)
# write data byte lane i holds fill byte + i
R 00000040 ffffffff 00
R 00000040 ffffffff 00
W 00000040 0000ff0f 10
R 00000040 ffffffff 00
R 00000240 ffffffff 00
W 00000240 ffffffff 20
R 00000240 ffffffff 00
R 00000040 ffffffff 00
R 00000440 ffffffff 00
R 00000240 ffffffff 00
R 00000040 ffffffff 00
R 00000440 ffffffff 00
R 00001000 ffffffff 00
W 00001013 80000001 33
R 00001000 ffffffff 00
R 0000ffe0 ffffffff 00
W 0000ffe4 00f00f00 a5
R 0000ffe0 ffffffff 00
W 00011000 ffff0000 44
R 00021000 ffffffff 00
R 00001000 ffffffff 00
R 00011000 ffffffff 00
W 00000260 0000000f 70
W 00000460 f0000000 80
R 00000660 ffffffff 00
R 00000260 ffffffff 00
R 00000460 ffffffff 00
R 0000ffe0 ffffffff 00

//--- testbench/cache_tb.sv
`default_nettype none

module cache_tb;

    localparam int resp_timeout = 200;

    logic         clk;
    logic         rst;
    logic [31:0]  mem_address;
    logic         mem_read;
    logic         mem_write;
    logic [31:0]  mem_byte_enable;
    logic [255:0] mem_wdata;
    logic [255:0] mem_rdata;
    logic         mem_resp;
    logic [31:0]  pmem_address;
    logic         pmem_read;
    logic         pmem_write;
    logic [255:0] pmem_wdata;
    logic [255:0] pmem_rdata;
    logic         pmem_resp;

    // memory model lines keyed by line address
    logic [255:0] mem_lines [logic [31:0]];
    logic [31:0]  lfsr;
    int           mem_wait;

    int timeouts;
    int ops_issued;
    logic file_error;

    always #10 clk = ~clk;

    cache_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    cache_checker chk0 (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata)
    );

    // ******************************
    // helpers
    // ******************************

    // fibonacci lfsr with taps 32 22 2 1
    // stepped once per latency bit taken
    function automatic int draw_latency();
        logic [2:0] bits;
        for (int i = 0; i < 3; i++) begin
            bits[i] = lfsr[31];
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
        return int'(bits) + 1;
    endfunction

    // untouched memory holds its low address byte xor 5a in each byte
    function automatic logic [255:0] fetch_line(input logic [31:0] base);
        logic [255:0] line;
        logic [31:0]  a;
        if (mem_lines.exists(base)) begin
            return mem_lines[base];
        end
        for (int i = 0; i < 32; i++) begin
            a = base + i;
            line[8*i +: 8] = a[7:0] ^ 8'h5a;
        end
        return line;
    endfunction

    function automatic logic [255:0] lane_data(input logic [7:0] fill);
        logic [255:0] d;
        for (int i = 0; i < 32; i++) begin
            d[8*i +: 8] = fill + 8'(i);
        end
        return d;
    endfunction

    // hold one request until mem_resp
    task automatic run_op(input logic [7:0] kind, input logic [31:0] addr,
                          input logic [31:0] be, input logic [7:0] fill);
        logic got;
        got             = 1'b0;
        mem_address     = addr;
        mem_read        = (kind == "R");
        mem_write       = (kind == "W");
        mem_byte_enable = be;
        mem_wdata       = lane_data(fill);
        ops_issued++;
        for (int c = 0; c < resp_timeout && !got; c++) begin
            @(negedge clk);
            got = mem_resp;
            @(posedge clk);
            #2;
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
        if (!got) begin
            timeouts++;
            $display("timeout: no mem_resp for %c %h within %0d cycles", kind, addr,
                     resp_timeout);
        end
    endtask

    // ******************************
    // memory model
    // ******************************

    initial begin
        pmem_resp  = 1'b0;
        pmem_rdata = '0;
        mem_wait   = 0;
        forever begin
            @(posedge clk);
            #2;
            if (pmem_resp) begin
                pmem_resp = 1'b0;
            end else if (rst) begin
                mem_wait = 0;
            end else if (mem_wait > 0) begin
                mem_wait--;
                if (mem_wait == 0) begin
                    if (pmem_write) begin
                        mem_lines[pmem_address] = pmem_wdata;
                    end else begin
                        pmem_rdata = fetch_line(pmem_address);
                    end
                    pmem_resp = 1'b1;
                end
            end else if (pmem_read || pmem_write) begin
                mem_wait = draw_latency();
            end
        end
    end

    // ******************************
    // stimulus
    // ******************************

    initial begin
        int          fd;
        int          code;
        string       line;
        logic [7:0]  kind;
        logic [31:0] addr;
        logic [31:0] be;
        logic [7:0]  fill;

        clk             = 1'b0;
        rst             = 1'b1;
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        lfsr            = 32'hc6461238;
        timeouts        = 0;
        ops_issued      = 0;
        file_error      = 1'b0;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        fd = $fopen("testbench/cache_stim.txt", "r");
        if (fd == 0) begin
            file_error = 1'b1;
            $display("could not open testbench/cache_stim.txt");
        end else begin
            while (!$feof(fd) && timeouts == 0) begin
                code = $fgets(line, fd);
                // skip comments and blank lines
                if (code > 0 && line.len() > 0 && line[0] != "#") begin
                    code = $sscanf(line, "%c %h %h %h", kind, addr, be, fill);
                    if (code == 4) begin
                        run_op(kind, addr, be, fill);
                    end
                end
            end
            $fclose(fd);
        end

        repeat (3) @(posedge clk);

        $display("summary: %0d checker errors, %0d timeouts, %0d of %0d ops answered",
                 chk0.errors, timeouts, chk0.resp_count, ops_issued);
        if (chk0.errors == 0 && timeouts == 0 && !file_error && ops_issued > 0 &&
            chk0.resp_count == ops_issued) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
